/* hw/pdp8Pkg.sv */
/* Machine-level PDP-8 definitions: 12-bit words and addresses, 4K core.
   OPR bit positions follow the standard group 1 and group 2 layouts. */
package pdp8Pkg;

  typedef logic [11:0] word_t;
  typedef logic [11:0] addr_t;
  typedef logic [2:0]  opcode_t;

  // Full 4K field, no extended memory
  localparam int memWords = 4096;

  // Auto-index locations on page zero
  localparam addr_t autoIdxLo = 12'o0010;
  localparam addr_t autoIdxHi = 12'o0017;

  // Major opcodes
  localparam opcode_t opAND = 3'o0;
  localparam opcode_t opTAD = 3'o1;
  localparam opcode_t opISZ = 3'o2;
  localparam opcode_t opDCA = 3'o3;
  localparam opcode_t opJMS = 3'o4;
  localparam opcode_t opJMP = 3'o5;
  localparam opcode_t opIOT = 3'o6;
  localparam opcode_t opOPR = 3'o7;

  // Memory-reference fields
  localparam int opLsb   = 9;
  localparam int indBit  = 8;
  localparam int pageBit = 7;
  localparam int offsetW = 7;

  // OPR group select
  localparam int grp2Bit = 8;
  localparam int grp3Bit = 0;

  // Group 1 micro-ops
  localparam int claBit   = 7;
  localparam int cllBit   = 6;
  localparam int cmaBit   = 5;
  localparam int cmlBit   = 4;
  localparam int rarBit   = 3;
  localparam int ralBit   = 2;
  localparam int twiceBit = 1;
  localparam int iacBit   = 0;

  // Group 2 tests, CLA shares bit 7 with group 1
  localparam int smaBit   = 6;
  localparam int szaBit   = 5;
  localparam int snlBit   = 4;
  localparam int senseBit = 3;
  localparam int hltBit   = 1;

endpackage

/* hw/cpuCtrlPkg.sv */
/* Sequencer states and the structs passed between panel, sequencer, AC and memory.
   Depends on pdp8Pkg for word and address widths. */
package cpuCtrlPkg;

  // One major state per cycle
  typedef enum logic [2:0] {
    IDLE,
    FETCH_ADDR,
    FETCH_READ,
    DEFER_READ,
    AUTOINC_WRITE,
    EXEC_READ,
    EXEC_WRITE,
    EXEC_SKIP
  } majorState_e;

  // Accumulator operation select
  typedef enum logic [1:0] {
    AC_NONE,
    AC_AND,
    AC_TAD,
    AC_OPR
  } acOp_e;

  // Single memory port request, read data comes back a cycle later
  typedef struct packed {
    pdp8Pkg::addr_t addr;
    pdp8Pkg::word_t wdata;
    logic           wr;
  } memReq_t;

  // AC control, oprWord is IR[8:0]
  typedef struct packed {
    acOp_e          op;
    pdp8Pkg::word_t operand;
    logic [8:0]     oprWord;
    logic           load;
  } acCtrl_t;

  // Panel strobes toward the sequencer
  typedef struct packed {
    logic           start;
    pdp8Pkg::addr_t startAddr;
    logic           clear;
  } panelCmd_t;

endpackage

/* hw/frontPanel.sv */
/* Panel access to memory only while halted; deposits while running are dropped.
   Strobes are single-cycle pulses from the switch debouncers. */
`timescale 1ns/1ps

module frontPanel (
  input  logic                CLK,
  input  logic                rstN,
  input  logic                clearSw,
  input  logic                runSw,
  input  logic                depositSw,
  input  pdp8Pkg::addr_t      switchAddr,
  input  pdp8Pkg::word_t      switchData,
  input  pdp8Pkg::addr_t      examAddr,
  input  logic                haltPulse,
  input  cpuCtrlPkg::memReq_t cpuReq,
  output cpuCtrlPkg::panelCmd_t cmd,
  output logic                running,
  output cpuCtrlPkg::memReq_t memReq
);

  // Run flip-flop
  // Clear beats halt, halt beats run
  always_ff @(posedge CLK) begin
    if (!rstN || clearSw) begin
      running <= 1'b0;
    end else if (haltPulse) begin
      running <= 1'b0;
    end else if (runSw) begin
      running <= 1'b1;
    end
  end

  // Start only from halt, sequencer loads PC on the same edge as the run flop
  assign cmd.start     = runSw && !running;
  assign cmd.startAddr = switchAddr;
  // Clear takes effect on the edge that samples it
  assign cmd.clear     = clearSw;

  // Memory port owner
  always_comb begin
    if (running) begin
      // Processor owns the port
      memReq = cpuReq;
    end else if (depositSw) begin
      // Deposit writes switch data at the switch address
      memReq = '{addr: switchAddr, wdata: switchData, wr: 1'b1};
    end else begin
      // Idle panel keeps reading the examine address
      memReq = '{addr: examAddr, wdata: switchData, wr: 1'b0};
    end
  end

endmodule

/* hw/coreMemory.sv */
/* 4K x 12 single-port RAM, read-first: a read on a write edge returns old data.
   Contents survive reset and panel clear, as real core does. */
`timescale 1ns/1ps

module coreMemory (
  input  logic                CLK,
  input  cpuCtrlPkg::memReq_t req,
  output pdp8Pkg::word_t      rdata
);

  // Storage array
  pdp8Pkg::word_t mem [pdp8Pkg::memWords];

  always_ff @(posedge CLK) begin
    // Write lands on the same edge as the request
    if (req.wr) begin
      mem[req.addr] <= req.wdata;
    end
    // Registered read, valid one cycle after the address
    rdata <= mem[req.addr];
  end

endmodule

/* hw/instrSequencer.sv */
/* Major-state sequencer; relies on read-first memory during the auto-index write.
   IOT and group 3 words run as no-ops. */
`timescale 1ns/1ps

module instrSequencer (
  input  logic                  CLK,
  input  logic                  rstN,
  input  cpuCtrlPkg::panelCmd_t cmd,
  input  logic                  running,
  input  pdp8Pkg::word_t        rdata,
  input  pdp8Pkg::word_t        acValue,
  input  logic                  skip,
  output cpuCtrlPkg::memReq_t   memReq,
  output cpuCtrlPkg::acCtrl_t   acCtl,
  output logic                  haltPulse,
  output pdp8Pkg::addr_t        pc,
  output pdp8Pkg::word_t        ir
);

  cpuCtrlPkg::majorState_e state, stateNext;
  pdp8Pkg::addr_t  pcNext;
  pdp8Pkg::addr_t  ea, eaNext;
  pdp8Pkg::addr_t  eaDirect;
  pdp8Pkg::addr_t  ptrTarget;
  pdp8Pkg::word_t  inst;
  pdp8Pkg::opcode_t opcode;
  logic            irLoad;
  logic            isGrp3;

  // Page zero window check for auto-index pointers
  function automatic logic inAutoWindow(pdp8Pkg::addr_t a);
    inAutoWindow = (a >= pdp8Pkg::autoIdxLo) && (a <= pdp8Pkg::autoIdxHi);
  endfunction

  // Where a memory-reference instruction goes once its address is known
  function automatic cpuCtrlPkg::majorState_e operandState(pdp8Pkg::opcode_t code);
    case (code)
      pdp8Pkg::opAND, pdp8Pkg::opTAD, pdp8Pkg::opISZ: operandState = cpuCtrlPkg::EXEC_READ;
      pdp8Pkg::opDCA, pdp8Pkg::opJMS:                 operandState = cpuCtrlPkg::EXEC_WRITE;
      // JMP is done once the address is known
      default:                                        operandState = cpuCtrlPkg::FETCH_ADDR;
    endcase
  endfunction

  // Instruction arrives on rdata during FETCH_READ, IR holds it afterwards
  assign inst   = (state == cpuCtrlPkg::FETCH_READ) ? rdata : ir;
  assign opcode = inst[pdp8Pkg::opLsb +: $bits(pdp8Pkg::opcode_t)];
  assign isGrp3 = inst[pdp8Pkg::grp2Bit] && inst[pdp8Pkg::grp3Bit];

  // Page zero or current page, PC still points at the instruction here
  assign eaDirect = inst[pdp8Pkg::pageBit] ?
                    {pc[11:pdp8Pkg::offsetW], inst[pdp8Pkg::offsetW-1:0]} :
                    {{(12-pdp8Pkg::offsetW){1'b0}}, inst[pdp8Pkg::offsetW-1:0]};

  // Pointer read back is pre-increment data, so add the auto-index step here
  assign ptrTarget = rdata + {11'b0, inAutoWindow(ea)};

  always_comb begin
    stateNext = state;
    pcNext    = pc;
    eaNext    = ea;
    irLoad    = 1'b0;
    haltPulse = 1'b0;
    memReq    = '{addr: pc, wdata: acValue, wr: 1'b0};
    acCtl     = '{op: cpuCtrlPkg::AC_NONE, operand: rdata, oprWord: ir[8:0], load: 1'b0};
    case (state)
      cpuCtrlPkg::IDLE: begin
        if (cmd.start) begin
          pcNext    = cmd.startAddr;
          stateNext = cpuCtrlPkg::FETCH_ADDR;
        end
      end
      cpuCtrlPkg::FETCH_ADDR: begin
        // Stop at an instruction boundary once the run flop drops
        stateNext = running ? cpuCtrlPkg::FETCH_READ : cpuCtrlPkg::IDLE;
      end
      cpuCtrlPkg::FETCH_READ: begin
        irLoad      = 1'b1;
        pcNext      = pc + 12'd1;
        eaNext      = eaDirect;
        // Start the operand or pointer read right away
        memReq.addr = eaDirect;
        if (opcode == pdp8Pkg::opIOT || (opcode == pdp8Pkg::opOPR && isGrp3)) begin
          stateNext = cpuCtrlPkg::FETCH_ADDR;
        end else if (opcode == pdp8Pkg::opOPR) begin
          stateNext = cpuCtrlPkg::EXEC_SKIP;
        end else if (inst[pdp8Pkg::indBit]) begin
          stateNext = inAutoWindow(eaDirect) ? cpuCtrlPkg::AUTOINC_WRITE :
                                               cpuCtrlPkg::DEFER_READ;
        end else begin
          stateNext = operandState(opcode);
          if (opcode == pdp8Pkg::opJMP) begin
            pcNext = eaDirect;
          end
        end
      end
      cpuCtrlPkg::AUTOINC_WRITE: begin
        // Bump pointer in place, same edge reads back the old value
        memReq    = '{addr: ea, wdata: rdata + 12'd1, wr: 1'b1};
        stateNext = cpuCtrlPkg::DEFER_READ;
      end
      cpuCtrlPkg::DEFER_READ: begin
        eaNext      = ptrTarget;
        memReq.addr = ptrTarget;
        stateNext   = operandState(opcode);
        if (opcode == pdp8Pkg::opJMP) begin
          pcNext = ptrTarget;
        end
      end
      cpuCtrlPkg::EXEC_READ: begin
        if (opcode == pdp8Pkg::opISZ) begin
          memReq    = '{addr: ea, wdata: rdata + 12'd1, wr: 1'b1};
          // Operand of 7777 wraps to zero
          stateNext = (rdata == 12'o7777) ? cpuCtrlPkg::EXEC_SKIP : cpuCtrlPkg::FETCH_ADDR;
        end else begin
          acCtl.op      = (opcode == pdp8Pkg::opAND) ? cpuCtrlPkg::AC_AND : cpuCtrlPkg::AC_TAD;
          acCtl.operand = rdata;
          acCtl.load    = 1'b1;
          // Overlap next fetch with the AC load
          memReq.addr   = pc;
          stateNext     = cpuCtrlPkg::FETCH_READ;
        end
      end
      cpuCtrlPkg::EXEC_WRITE: begin
        memReq.addr = ea;
        memReq.wr   = 1'b1;
        if (opcode == pdp8Pkg::opJMS) begin
          // Return address is the already incremented PC
          memReq.wdata = pc;
          pcNext       = ea + 12'd1;
        end else begin
          // DCA clears AC by ANDing with zero
          acCtl.op      = cpuCtrlPkg::AC_AND;
          acCtl.operand = '0;
          acCtl.load    = 1'b1;
        end
        stateNext = cpuCtrlPkg::FETCH_ADDR;
      end
      cpuCtrlPkg::EXEC_SKIP: begin
        stateNext = cpuCtrlPkg::FETCH_ADDR;
        if (opcode == pdp8Pkg::opISZ) begin
          pcNext = pc + 12'd1;
        end else begin
          acCtl.op   = cpuCtrlPkg::AC_OPR;
          acCtl.load = 1'b1;
          // skip is already gated to group 2 in the AC unit
          if (skip) begin
            pcNext = pc + 12'd1;
          end
          if (ir[pdp8Pkg::grp2Bit] && ir[pdp8Pkg::hltBit]) begin
            haltPulse = 1'b1;
            stateNext = cpuCtrlPkg::IDLE;
          end
        end
      end
      default: stateNext = cpuCtrlPkg::IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rstN || cmd.clear) begin
      state <= cpuCtrlPkg::IDLE;
      pc    <= '0;
      ir    <= '0;
    end else begin
      state <= stateNext;
      pc    <= pcNext;
      if (irLoad) begin
        ir <= rdata;
      end
    end
  end

  // Effective address register
  always_ff @(posedge CLK) begin
    ea <= eaNext;
  end

endmodule

/* hw/accumulatorUnit.sv */
/* AC and link; group 2 skip is combinational from the AC before the load edge.
   Group 3 words leave AC and link unchanged. */
`timescale 1ns/1ps

module accumulatorUnit (
  input  logic                CLK,
  input  logic                rstN,
  input  logic                clear,
  input  cpuCtrlPkg::acCtrl_t ctl,
  output pdp8Pkg::word_t      acValue,
  output logic                link,
  output logic                skip
);

  pdp8Pkg::word_t acNext;
  logic           linkNext;
  logic [12:0]    la;
  logic [12:0]    sum;
  logic           incCarry;
  logic           skipTest;
  logic           isGrp2;
  logic           isGrp3;

  assign isGrp2 = ctl.oprWord[pdp8Pkg::grp2Bit];
  assign isGrp3 = isGrp2 && ctl.oprWord[pdp8Pkg::grp3Bit];

  // TAD carry out of bit 0
  assign sum = {1'b0, acValue} + {1'b0, ctl.operand};

  // OR of selected conditions, sense bit inverts to an AND of the negations
  assign skipTest = (ctl.oprWord[pdp8Pkg::smaBit] && acValue[11]) ||
                    (ctl.oprWord[pdp8Pkg::szaBit] && (acValue == '0)) ||
                    (ctl.oprWord[pdp8Pkg::snlBit] && link);
  assign skip = isGrp2 && !isGrp3 && (skipTest ^ ctl.oprWord[pdp8Pkg::senseBit]);

  // Group 1 chain, la is {link, AC}
  always_comb begin
    la       = {link, acValue};
    incCarry = 1'b0;
    // 1: clear
    if (ctl.oprWord[pdp8Pkg::claBit]) la[11:0] = '0;
    if (ctl.oprWord[pdp8Pkg::cllBit]) la[12] = 1'b0;
    // 2: complement
    if (ctl.oprWord[pdp8Pkg::cmaBit]) la[11:0] = ~la[11:0];
    if (ctl.oprWord[pdp8Pkg::cmlBit]) la[12] = ~la[12];
    // 3: increment, carry flips link
    if (ctl.oprWord[pdp8Pkg::iacBit]) begin
      {incCarry, la[11:0]} = {1'b0, la[11:0]} + 13'd1;
      la[12] = la[12] ^ incCarry;
    end
    // 4: rotate through link, twice bit alone is BSW
    if (ctl.oprWord[pdp8Pkg::rarBit]) begin
      la = ctl.oprWord[pdp8Pkg::twiceBit] ? {la[1:0], la[12:2]} : {la[0], la[12:1]};
    end else if (ctl.oprWord[pdp8Pkg::ralBit]) begin
      la = ctl.oprWord[pdp8Pkg::twiceBit] ? {la[10:0], la[12:11]} : {la[11:0], la[12]};
    end else if (ctl.oprWord[pdp8Pkg::twiceBit]) begin
      la = {la[12], la[5:0], la[11:6]};
    end
  end

  always_comb begin
    acNext   = acValue;
    linkNext = link;
    case (ctl.op)
      cpuCtrlPkg::AC_AND: acNext = acValue & ctl.operand;
      cpuCtrlPkg::AC_TAD: begin
        acNext   = sum[11:0];
        linkNext = link ^ sum[12];
      end
      cpuCtrlPkg::AC_OPR: begin
        if (!isGrp2) begin
          {linkNext, acNext} = la;
        end else if (!isGrp3 && ctl.oprWord[pdp8Pkg::claBit]) begin
          // Group 2 CLA after the skip test
          acNext = '0;
        end
      end
      default: acNext = acValue;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rstN || clear) begin
      acValue <= '0;
      link    <= 1'b0;
    end else if (ctl.load) begin
      acValue <= acNext;
      link    <= linkNext;
    end
  end

endmodule

/* hw/panelLamps.sv */
/* One register stage behind the machine state.
   Instruction lamps go dark whenever the machine is halted. */
`timescale 1ns/1ps

module panelLamps (
  input  logic           CLK,
  input  logic           rstN,
  input  pdp8Pkg::addr_t pc,
  input  pdp8Pkg::word_t ir,
  input  pdp8Pkg::word_t acValue,
  input  logic           link,
  input  logic           running,
  output pdp8Pkg::addr_t lampPc,
  output pdp8Pkg::word_t lampAc,
  output logic           lampLink,
  output logic           lampRun,
  output logic [7:0]     lampInst
);

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      lampPc   <= '0;
      lampAc   <= '0;
      lampLink <= 1'b0;
      lampRun  <= 1'b0;
      lampInst <= '0;
    end else begin
      lampPc   <= pc;
      lampAc   <= acValue;
      lampLink <= link;
      lampRun  <= running;
      // One-hot in opcode order, AND is bit 0
      lampInst <= running ? (8'b1 << ir[pdp8Pkg::opLsb +: $bits(pdp8Pkg::opcode_t)]) : 8'b0;
    end
  end

endmodule

/* hw/pdp8Top.sv */
/* PDP-8 core with front panel; panel deposit and examine work only while halted.
   Examine data is the shared memory read port. */
`timescale 1ns/1ps

module pdp8Top (
  input  logic           CLK,
  input  logic           rstN,
  input  logic           clearSw,
  input  logic           runSw,
  input  pdp8Pkg::addr_t switchAddr,
  input  pdp8Pkg::word_t switchData,
  input  logic           depositSw,
  input  pdp8Pkg::addr_t examAddr,
  output pdp8Pkg::word_t examData,
  output pdp8Pkg::addr_t lampPc,
  output pdp8Pkg::word_t lampAc,
  output logic           lampLink,
  output logic           lampRun,
  output logic [7:0]     lampInst
);

  cpuCtrlPkg::panelCmd_t panelCmd;
  cpuCtrlPkg::memReq_t   cpuReq;
  cpuCtrlPkg::memReq_t   memReq;
  cpuCtrlPkg::acCtrl_t   acCtl;
  pdp8Pkg::word_t        rdata;
  pdp8Pkg::word_t        acValue;
  pdp8Pkg::word_t        ir;
  pdp8Pkg::addr_t        pc;
  logic                  running;
  logic                  haltPulse;
  logic                  link;
  logic                  skip;

  // Panel sees whatever the memory last read
  assign examData = rdata;

  frontPanel iPanel (
    .CLK(CLK), .rstN(rstN),
    .clearSw(clearSw), .runSw(runSw), .depositSw(depositSw),
    .switchAddr(switchAddr), .switchData(switchData), .examAddr(examAddr),
    .haltPulse(haltPulse), .cpuReq(cpuReq),
    .cmd(panelCmd), .running(running), .memReq(memReq)
  );

  coreMemory iMemory (
    .CLK(CLK), .req(memReq), .rdata(rdata)
  );

  instrSequencer iSequencer (
    .CLK(CLK), .rstN(rstN), .cmd(panelCmd), .running(running),
    .rdata(rdata), .acValue(acValue), .skip(skip),
    .memReq(cpuReq), .acCtl(acCtl), .haltPulse(haltPulse), .pc(pc), .ir(ir)
  );

  accumulatorUnit iAcc (
    .CLK(CLK), .rstN(rstN), .clear(panelCmd.clear), .ctl(acCtl),
    .acValue(acValue), .link(link), .skip(skip)
  );

  panelLamps iLamps (
    .CLK(CLK), .rstN(rstN), .pc(pc), .ir(ir), .acValue(acValue),
    .link(link), .running(running),
    .lampPc(lampPc), .lampAc(lampAc), .lampLink(lampLink),
    .lampRun(lampRun), .lampInst(lampInst)
  );

endmodule

/* testbench/pdp8Tb.sv */
/* Loads each table program into a cleared machine, runs it to HLT and checks AC, link, PC, one word.
   Memory is not cleared between tests, so every program deposits all the words it reads. */
`timescale 1ns/1ps

module pdp8Tb;

  localparam int maxTests = 32;
  localparam int maxWords = 16;

  logic           CLK;
  logic           rstN;
  logic           clearSw;
  logic           runSw;
  logic           depositSw;
  pdp8Pkg::addr_t switchAddr;
  pdp8Pkg::word_t switchData;
  pdp8Pkg::addr_t examAddr;
  pdp8Pkg::word_t examData;
  pdp8Pkg::addr_t lampPc;
  pdp8Pkg::word_t lampAc;
  logic           lampLink;
  logic           lampRun;
  logic [7:0]     lampInst;

  // Test table, one row per program
  string          testName  [maxTests];
  int             wordCount [maxTests];
  pdp8Pkg::addr_t progAddr  [maxTests][maxWords];
  pdp8Pkg::word_t progData  [maxTests][maxWords];
  pdp8Pkg::addr_t startAddr [maxTests];
  pdp8Pkg::word_t expAc     [maxTests];
  logic           expLink   [maxTests];
  pdp8Pkg::addr_t expPc     [maxTests];
  pdp8Pkg::addr_t chkAddr   [maxTests];
  pdp8Pkg::word_t chkValue  [maxTests];
  int             numTests;

  logic [31:0] rngState;
  int          mismatches;
  int          otherErrors;
  int          cycleCount = 0;
  int          cycleLimit = 0;

  pdp8Top i_dut (
    .CLK(CLK), .rstN(rstN), .clearSw(clearSw), .runSw(runSw),
    .switchAddr(switchAddr), .switchData(switchData), .depositSw(depositSw),
    .examAddr(examAddr), .examData(examData), .lampPc(lampPc), .lampAc(lampAc),
    .lampLink(lampLink), .lampRun(lampRun), .lampInst(lampInst)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Run limit, set once the table is built
  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout: machine did not halt within %0d cycles", cycleLimit);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic pdp8Pkg::word_t randWord();
    rngState = xorshift32(rngState);
    return rngState[11:0];
  endfunction

  // Group 1 reference: clear, complement, increment, then rotate or swap
  function automatic logic [12:0] group1Result(logic [12:0] la, pdp8Pkg::word_t w);
    logic [12:0] r;
    int          turns;
    r = la;
    turns = w[1] ? 2 : 1;
    if (w[7]) r[11:0] = 12'o0000;
    if (w[6]) r[12] = 1'b0;
    if (w[5]) r[11:0] = ~r[11:0];
    if (w[4]) r[12] = ~r[12];
    if (w[0]) begin
      // Carry out of 7777 flips the link
      if (r[11:0] == 12'o7777) r[12] = ~r[12];
      r[11:0] = r[11:0] + 12'd1;
    end
    for (int i = 0; i < turns; i++) begin
      if (w[3]) r = {r[0], r[12:1]};
      else if (w[2]) r = {r[11:0], r[12]};
    end
    // Twice bit with no rotate is a byte swap
    if (w[1] && !w[3] && !w[2]) r[11:0] = {r[5:0], r[11:6]};
    return r;
  endfunction

  task automatic beginTest(string name, pdp8Pkg::addr_t start);
    testName[numTests]  = name;
    startAddr[numTests] = start;
    wordCount[numTests] = 0;
  endtask

  task automatic putWord(pdp8Pkg::addr_t a, pdp8Pkg::word_t d);
    progAddr[numTests][wordCount[numTests]] = a;
    progData[numTests][wordCount[numTests]] = d;
    wordCount[numTests] = wordCount[numTests] + 1;
  endtask

  // haltPc is the word after the HLT
  task automatic endTest(pdp8Pkg::word_t ac, logic lnk, pdp8Pkg::addr_t haltPc,
                         pdp8Pkg::addr_t a, pdp8Pkg::word_t v);
    expAc[numTests]    = ac;
    expLink[numTests]  = lnk;
    expPc[numTests]    = haltPc;
    chkAddr[numTests]  = a;
    chkValue[numTests] = v;
    numTests = numTests + 1;
  endtask

  // CLA CLL, TAD operand, optional CML, micro-op, HLT
  task automatic addGroup1(string name, pdp8Pkg::word_t w);
    pdp8Pkg::word_t operand;
    logic           lnk;
    logic [12:0]    res;
    operand = randWord();
    lnk = rngState[23];
    res = group1Result({lnk, operand}, w);
    beginTest(name, 12'o2000);
    putWord(12'o2000, 12'o7300);
    putWord(12'o2001, 12'o1250);
    putWord(12'o2002, lnk ? 12'o7020 : 12'o7000);
    putWord(12'o2003, w);
    putWord(12'o2004, 12'o7402);
    putWord(12'o2050, operand);
    endTest(res[11:0], res[12], 12'o2005, 12'o2050, operand);
  endtask

  // Skip word guards an IAC, skips is the outcome the case calls for
  task automatic addGroup2(string name, pdp8Pkg::word_t w, pdp8Pkg::word_t operand, logic lnk,
                           logic skips);
    logic [12:0] res;
    res = {lnk, operand};
    if (!skips) begin
      res = {lnk ^ (operand == 12'o7777), operand + 12'd1};
    end
    beginTest(name, 12'o2200);
    putWord(12'o2200, 12'o7300);
    putWord(12'o2201, 12'o1250);
    putWord(12'o2202, lnk ? 12'o7020 : 12'o7000);
    putWord(12'o2203, w);
    putWord(12'o2204, 12'o7001);
    putWord(12'o2205, 12'o7402);
    putWord(12'o2250, operand);
    endTest(res[11:0], res[12], 12'o2206, 12'o2250, operand);
  endtask

  task automatic buildTable();
    pdp8Pkg::word_t r1;
    pdp8Pkg::word_t r2;
    logic [12:0]    sum;
    // TAD, DCA then AND on current page
    r1 = randWord();
    r2 = randWord();
    sum = {1'b0, r1} + {1'b0, r2};
    beginTest("tadDcaAnd", 12'o0200);
    putWord(12'o0200, 12'o7300);
    putWord(12'o0201, 12'o1250);
    putWord(12'o0202, 12'o1251);
    putWord(12'o0203, 12'o3252);
    putWord(12'o0204, 12'o1250);
    putWord(12'o0205, 12'o0251);
    putWord(12'o0206, 12'o7402);
    putWord(12'o0250, r1);
    putWord(12'o0251, r2);
    endTest(r1 & r2, sum[12], 12'o0207, 12'o0252, sum[11:0]);
    // Page zero plus current page 0400
    r1 = randWord();
    r2 = randWord();
    sum = {1'b0, r1} + {1'b0, r2};
    beginTest("pageZero", 12'o0400);
    putWord(12'o0400, 12'o7300);
    putWord(12'o0401, 12'o1060);
    putWord(12'o0402, 12'o1260);
    putWord(12'o0403, 12'o3061);
    putWord(12'o0404, 12'o1061);
    putWord(12'o0405, 12'o7402);
    putWord(12'o0060, r1);
    putWord(12'o0460, r2);
    endTest(sum[11:0], sum[12], 12'o0406, 12'o0061, sum[11:0]);
    // ISZ on 7777 skips the IAC
    beginTest("iszSkip", 12'o0600);
    putWord(12'o0600, 12'o7300);
    putWord(12'o0601, 12'o2250);
    putWord(12'o0602, 12'o7001);
    putWord(12'o0603, 12'o1251);
    putWord(12'o0604, 12'o7402);
    putWord(12'o0650, 12'o7777);
    putWord(12'o0651, 12'o0005);
    endTest(12'o0005, 1'b0, 12'o0605, 12'o0650, 12'o0000);
    // Subroutine at 1050 returns through JMP I 1050
    beginTest("jmsReturn", 12'o1000);
    putWord(12'o1000, 12'o7300);
    putWord(12'o1001, 12'o4250);
    putWord(12'o1002, 12'o1253);
    putWord(12'o1003, 12'o7402);
    putWord(12'o1050, 12'o0000);
    putWord(12'o1051, 12'o7001);
    putWord(12'o1052, 12'o5650);
    putWord(12'o1053, 12'o0030);
    endTest(12'o0031, 1'b0, 12'o1004, 12'o1050, 12'o1002);
    // Pointer 1277 must become 1300 before the jump, else HLT at 1277
    beginTest("autoIndexJmp", 12'o1200);
    putWord(12'o1200, 12'o7300);
    putWord(12'o1201, 12'o5410);
    putWord(12'o0010, 12'o1277);
    putWord(12'o1277, 12'o7402);
    putWord(12'o1300, 12'o7001);
    putWord(12'o1301, 12'o7402);
    endTest(12'o0001, 1'b0, 12'o1302, 12'o0010, 12'o1300);
    addGroup1("cla", 12'o7200);
    addGroup1("cll", 12'o7100);
    addGroup1("cma", 12'o7040);
    addGroup1("cml", 12'o7020);
    addGroup1("iac", 12'o7001);
    addGroup1("rar", 12'o7010);
    addGroup1("ral", 12'o7004);
    addGroup1("rtr", 12'o7012);
    addGroup1("rtl", 12'o7006);
    addGroup1("bsw", 12'o7002);
    addGroup1("cmaIac", 12'o7041);
    addGroup1("claCma", 12'o7240);
    r1 = randWord();
    addGroup2("smaNeg", 12'o7500, r1 | 12'o4000, 1'b0, 1'b1);
    addGroup2("smaPos", 12'o7500, r1 & 12'o3777, 1'b0, 1'b0);
    addGroup2("spaNeg", 12'o7510, r1 | 12'o4000, 1'b0, 1'b0);
    addGroup2("spaPos", 12'o7510, r1 & 12'o3777, 1'b0, 1'b1);
    addGroup2("szaZero", 12'o7440, 12'o0000, 1'b0, 1'b1);
    addGroup2("snaZero", 12'o7450, 12'o0000, 1'b0, 1'b0);
    addGroup2("szaNonzero", 12'o7440, r1 | 12'o0001, 1'b0, 1'b0);
    addGroup2("snaNonzero", 12'o7450, r1 | 12'o0001, 1'b0, 1'b1);
    addGroup2("snlSet", 12'o7420, r1, 1'b1, 1'b1);
    addGroup2("szlSet", 12'o7430, r1, 1'b1, 1'b0);
    addGroup2("snlClear", 12'o7420, r1, 1'b0, 1'b0);
    addGroup2("szlClear", 12'o7430, r1, 1'b0, 1'b1);
  endtask

  task automatic compareWord(string name, string what, pdp8Pkg::word_t expected,
                             pdp8Pkg::word_t actual);
    if (actual !== expected) begin
      $display("mismatch %s %s: expected %o, actual %o", name, what, expected, actual);
      mismatches = mismatches + 1;
    end
  endtask

  // Memory writes on the second edge
  task automatic deposit(pdp8Pkg::addr_t a, pdp8Pkg::word_t d);
    @(posedge CLK);
    switchAddr <= a;
    switchData <= d;
    depositSw  <= 1'b1;
    @(posedge CLK);
    depositSw  <= 1'b0;
  endtask

  task automatic examine(pdp8Pkg::addr_t a, output pdp8Pkg::word_t d);
    @(posedge CLK);
    examAddr <= a;
    @(posedge CLK);
    @(posedge CLK);
    @(negedge CLK);
    d = examData;
  endtask

  task automatic pulseClear();
    @(posedge CLK);
    clearSw <= 1'b1;
    @(posedge CLK);
    clearSw <= 1'b0;
  endtask

  task automatic startRun(pdp8Pkg::addr_t a);
    @(posedge CLK);
    switchAddr <= a;
    runSw      <= 1'b1;
    @(posedge CLK);
    runSw      <= 1'b0;
    // Run lamp trails the run flop by one cycle
    while (!lampRun) @(negedge CLK);
  endtask

  task automatic waitHalt();
    while (lampRun) @(negedge CLK);
  endtask

  initial begin
    pdp8Pkg::word_t got;
    pdp8Pkg::word_t v;
    pdp8Pkg::word_t saved [4];
    int             budget;
    rstN        = 1'b0;
    clearSw     = 1'b0;
    runSw       = 1'b0;
    depositSw   = 1'b0;
    switchAddr  = '0;
    switchData  = '0;
    examAddr    = '0;
    rngState    = 32'd72058;
    numTests    = 0;
    mismatches  = 0;
    otherErrors = 0;
    buildTable();
    budget = 0;
    for (int t = 0; t < numTests; t++) begin
      budget = budget + wordCount[t] * 2 + 200;
    end
    // Directed deposit, examine and clear runs
    cycleLimit = budget + 600;
    repeat (3) @(posedge CLK);
    rstN <= 1'b1;

    for (int i = 0; i < 4; i++) begin
      saved[i] = randWord();
      deposit(12'(12'o3100 + i), saved[i]);
    end
    for (int i = 0; i < 4; i++) begin
      examine(12'(12'o3100 + i), got);
      compareWord("depositExamine", "memory", saved[i], got);
    end

    for (int t = 0; t < numTests; t++) begin
      pulseClear();
      for (int k = 0; k < wordCount[t]; k++) begin
        deposit(progAddr[t][k], progData[t][k]);
      end
      startRun(startAddr[t]);
      waitHalt();
      compareWord(testName[t], "AC", expAc[t], lampAc);
      compareWord(testName[t], "link", {11'b0, expLink[t]}, {11'b0, lampLink});
      compareWord(testName[t], "PC", expPc[t], lampPc);
      if (lampInst != 8'b0) begin
        $display("%s: instruction lamps still lit after halt", testName[t]);
        otherErrors = otherErrors + 1;
      end
      examine(chkAddr[t], got);
      compareWord(testName[t], "memory", chkValue[t], got);
    end

    // IAC / JMP loop stopped by clear
    pulseClear();
    deposit(12'o2400, 12'o7001);
    deposit(12'o2401, 12'o5200);
    v = randWord();
    deposit(12'o3000, v);
    startRun(12'o2400);
    repeat (10) @(negedge CLK);
    if (!$onehot(lampInst) || (lampInst & 8'b1010_0000) == 8'b0) begin
      $display("clearLoop: instruction lamps %b not one-hot for IAC or JMP", lampInst);
      otherErrors = otherErrors + 1;
    end
    // Panel write while running should be dropped
    deposit(12'o3000, ~v);
    pulseClear();
    waitHalt();
    compareWord("clearLoop", "AC", 12'o0000, lampAc);
    compareWord("clearLoop", "link", 12'o0000, {11'b0, lampLink});
    compareWord("clearLoop", "PC", 12'o0000, lampPc);
    if (lampInst != 8'b0) begin
      $display("clearLoop: instruction lamps still lit after clear");
      otherErrors = otherErrors + 1;
    end
    examine(12'o3000, got);
    compareWord("runningDeposit", "memory", v, got);

    $display("errors: %0d mismatches, %0d other failures, %0d table tests",
             mismatches, otherErrors, numTests);
    if (mismatches == 0 && otherErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* pdp8Cpu.f */
hw/pdp8Pkg.sv
hw/cpuCtrlPkg.sv
hw/frontPanel.sv
hw/coreMemory.sv
hw/instrSequencer.sv
hw/accumulatorUnit.sv
hw/panelLamps.sv
hw/pdp8Top.sv
testbench/pdp8Tb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the PDP-8 testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module pdp8Tb -f pdp8Cpu.f -o pdp8Sim
./obj_dir/pdp8Sim > sim.log
cat sim.log
if grep -q ">>> FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation finished without failures"
